//--- hdl/sys86MapPkg.sv
package sys86MapPkg;

	//////////////////////////////////////////////////////////////////////
	// Main CPU memory map
	//////////////////////////////////////////////////////////////////////

	// Region codes on address bits 15..13

	// 0000h-1FFFh sprite RAM
	localparam logic [2:0] regionSprite = 3'b000;
	// 2000h-3FFFh first video RAM
	localparam logic [2:0] regionVram0 = 3'b001;
	// 4000h-5FFFh second video RAM
	localparam logic [2:0] regionVram1 = 3'b010;
	// 6000h-7FFFh banked program ROM window
	localparam logic [2:0] regionRom6 = 3'b011;
	// Lowest code of the fixed ROM, everything from 8000h up
	localparam logic [2:0] regionHigh = 3'b100;

	//////////////////////////////////////////////////////////////////////
	// Write-only registers, compared on address bits 15..11
	//////////////////////////////////////////////////////////////////////

	// 8000h watchdog clear
	localparam logic [4:0] addrWatchdogHi = 5'b10000;

	// 8800h main CPU interrupt acknowledge
	localparam logic [4:0] addrMainAckHi = 5'b10001;

	// 9800h sound CPU interrupt acknowledge
	// Compared against the sound CPU bus, not the main one
	localparam logic [4:0] addrSoundAckHi = 5'b10011;

	// D000h first latch group, planes 0 and 1
	localparam logic [4:0] addrLatch0Hi = 5'b11010;
	// D800h second latch group, planes 2 and 3
	localparam logic [4:0] addrLatch1Hi = 5'b11011;

	//////////////////////////////////////////////////////////////////////
	// Watchdog
	//////////////////////////////////////////////////////////////////////

	// Vblank count at which the watchdog folds back to zero
	localparam int unsigned watchdogWrap = 10;

endpackage

//--- hdl/sys86VideoPkg.sv
package sys86VideoPkg;

	// Scroll planes, two per latch group
	localparam int planeCount = 4;

	// Program ROM bank number width
	localparam int bankWidth = 3;

	//////////////////////////////////////////////////////////////////////
	// Register offsets inside one latch group
	//////////////////////////////////////////////////////////////////////

	// Scroll X low byte
	localparam logic [2:0] offScrollXLo = 3'd0;
	// Priority plus scroll X bit 8
	localparam logic [2:0] offCtl = 3'd1;
	// Scroll Y
	localparam logic [2:0] offScrollY = 3'd2;
	// ROM bank, only on the first plane of a group
	localparam logic [2:0] offBank = 3'd3;
	// Second plane sits four bytes higher
	localparam logic [2:0] offPlaneB = 3'd4;

	//////////////////////////////////////////////////////////////////////
	// Latch data byte
	//////////////////////////////////////////////////////////////////////

	// Control byte view
	typedef struct packed {
		logic [2:0] prio;
		logic [3:0] unused;
		logic       scrollXHi;
	} latchCtl_t;

	// Bank byte view, bank in the low bits
	typedef struct packed {
		logic [7-bankWidth:0] unused;
		logic [bankWidth-1:0] bank;
	} latchBank_t;

	// Same CPU byte, decoded by offset
	typedef union packed {
		latchCtl_t  ctl;
		latchBank_t bnk;
	} latchData_u;

endpackage

//--- hdl/mainAddrDecoder.sv
`timescale 1ns/1ps

module mainAddrDecoder
	import sys86MapPkg::*;
#(
	parameter int WATCHDOG_WIDTH = 4
) (
	input  logic        clk6M,
	input  logic        rstN,
	// CPU phase reset level
	input  logic        clk0,
	// Main CPU bus
	input  logic [15:0] ma,
	input  logic        mweN,
	// Vertical blank, active low
	input  logic        vblaN,
	// Sound CPU address and write
	input  logic [15:11] sa,
	input  logic        sweN,
	// Chip selects
	output logic        mcs0N,
	output logic        mcs1N,
	output logic        mcs2N,
	output logic        mcs3N,
	output logic        mcs4N,
	output logic        mromN,
	// Latch group write strobes
	output logic        lth0N,
	output logic        lth1N,
	// CPU quadrature phase
	output logic        q,
	// Watchdog reset and interrupts
	output logic        mresN,
	output logic        mintN,
	output logic        sintN
);

	logic [2:0]                region;
	logic [4:0]                upper;
	logic                      mainWr;
	logic                      wdClear;
	logic                      mainAck;
	logic                      soundAck;
	logic [1:0]                phaseCnt;
	logic                      vblaSync;
	logic                      vblaSyncD;
	logic                      vblankFall;
	logic [WATCHDOG_WIDTH-1:0] wdCount;

	assign region = ma[15:13];
	assign upper  = ma[15:11];
	assign mainWr = ~mweN;

	//////////////////////////////////////////////////////////////////////
	// Memory map
	//////////////////////////////////////////////////////////////////////

	// Sprite RAM, read and write
	assign mcs2N = (region != regionSprite);
	// Video RAM pair
	assign mcs0N = (region != regionVram0);
	assign mcs1N = (region != regionVram1);
	// No device on this select
	assign mcs3N = 1'b1;
	// Banked ROM window, the mapper qualifies reads itself
	assign mcs4N = (region != regionRom6);
	// Fixed program ROM, reads only
	assign mromN = ~(mweN && (region >= regionHigh));

	// Latch strobes carry the write qualification
	assign lth0N = ~(mainWr && (upper == addrLatch0Hi));
	assign lth1N = ~(mainWr && (upper == addrLatch1Hi));

	// Write-only registers in the high region
	assign wdClear  = mainWr && (upper == addrWatchdogHi);
	assign mainAck  = mainWr && (upper == addrMainAckHi);
	assign soundAck = ~sweN && (sa == addrSoundAckHi);

	//////////////////////////////////////////////////////////////////////
	// CPU phase
	//////////////////////////////////////////////////////////////////////

	// Held at zero while clk0 is low, free running otherwise
	always_ff @(posedge clk6M or negedge rstN) begin
		if (!rstN) begin
			phaseCnt <= '0;
		end else if (!clk0) begin
			phaseCnt <= '0;
		end else begin
			phaseCnt <= phaseCnt + 2'd1;
		end
	end

	// Gray-style quadrature from the two low bits
	assign q = phaseCnt[1] ^ phaseCnt[0];

	//////////////////////////////////////////////////////////////////////
	// Vertical blank edge
	//////////////////////////////////////////////////////////////////////

	// Sample, then delay once to find the falling edge
	always_ff @(posedge clk6M or negedge rstN) begin
		if (!rstN) begin
			vblaSync  <= 1'b1;
			vblaSyncD <= 1'b1;
		end else begin
			vblaSync  <= vblaN;
			vblaSyncD <= vblaSync;
		end
	end

	// High for one cycle after the first low sample
	assign vblankFall = vblaSyncD & ~vblaSync;

	//////////////////////////////////////////////////////////////////////
	// Watchdog
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk6M or negedge rstN) begin
		if (!rstN) begin
			wdCount <= '0;
		end else if (wdClear) begin
			// CPU kicked the dog
			wdCount <= '0;
		end else if (vblankFall) begin
			if (wdCount == WATCHDOG_WIDTH'(watchdogWrap)) begin
				wdCount <= '0;
			end else begin
				wdCount <= wdCount + 1'b1;
			end
		end
	end

	// Reset asserted while the top bit is set
	assign mresN = ~wdCount[WATCHDOG_WIDTH-1];

	//////////////////////////////////////////////////////////////////////
	// Interrupts
	//////////////////////////////////////////////////////////////////////

	// Vblank raises both, each CPU clears its own
	always_ff @(posedge clk6M or negedge rstN) begin
		if (!rstN) begin
			mintN <= 1'b1;
			sintN <= 1'b1;
		end else begin
			if (vblankFall) begin
				mintN <= 1'b0;
			end else if (mainAck) begin
				mintN <= 1'b1;
			end
			// Vblank also takes priority over the sound acknowledge
			if (vblankFall) begin
				sintN <= 1'b0;
			end else if (soundAck) begin
				sintN <= 1'b1;
			end
		end
	end

endmodule

//--- hdl/scrollLatchBank.sv
`timescale 1ns/1ps

module scrollLatchBank
	import sys86MapPkg::*;
	import sys86VideoPkg::*;
(
	input  logic                                 clk6M,
	input  logic                                 rstN,
	// Group strobes, already write qualified
	input  logic                                 lth0N,
	input  logic                                 lth1N,
	// Register offset inside the group
	input  logic [2:0]                           offset,
	input  logic [7:0]                           data,
	// Per plane values
	output logic [planeCount-1:0][8:0]           scrollX,
	output logic [planeCount-1:0][7:0]           scrollY,
	output logic [planeCount-1:0][2:0]           prio,
	// One bank per group
	output logic [bankWidth-1:0]                 bank0,
	output logic [bankWidth-1:0]                 bank1
);

	// Groups follow the latch addresses in the memory map
	localparam int groupCount = planeCount / 2;

	latchData_u                            din;
	logic [groupCount-1:0]                 groupWe;
	logic [planeCount-1:0]                 planeWe;
	logic                                  planeSel;
	logic [2:0]                            baseOff;
	logic [groupCount-1:0][bankWidth-1:0]  bankReg;

	assign din = data;

	// Strobe order matches addrLatch0Hi then addrLatch1Hi
	assign groupWe = {~lth1N, ~lth0N};

	// Split offset into plane select and register
	assign planeSel = |(offset & offPlaneB);
	assign baseOff  = offset & ~offPlaneB;

	// Even plane takes the low offsets, odd plane the high ones
	always_comb begin
		for (int p = 0; p < planeCount; p++) begin
			planeWe[p] = groupWe[p / 2] && (planeSel == p[0]);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Register file
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk6M or negedge rstN) begin
		if (!rstN) begin
			scrollX <= '0;
			scrollY <= '0;
			prio    <= '0;
			bankReg <= '0;
		end else begin
			for (int p = 0; p < planeCount; p++) begin
				if (planeWe[p]) begin
					case (baseOff)
						// Low byte, bit 8 untouched
						offScrollXLo: scrollX[p][7:0] <= data;
						// Control byte view
						offCtl: begin
							scrollX[p][8] <= din.ctl.scrollXHi;
							prio[p]       <= din.ctl.prio;
						end
						offScrollY: scrollY[p] <= data;
						// Bank handled per group below
						default: ;
					endcase
				end
			end
			// Bank byte view, offset 7 falls through
			for (int g = 0; g < groupCount; g++) begin
				if (groupWe[g] && !planeSel && (baseOff == offBank)) begin
					bankReg[g] <= din.bnk.bank;
				end
			end
		end
	end

	assign bank0 = bankReg[0];
	assign bank1 = bankReg[1];

endmodule

//--- hdl/romBankMapper.sv
`timescale 1ns/1ps

module romBankMapper
	import sys86VideoPkg::*;
(
	input  logic                    clk6M,
	input  logic                    rstN,
	// Window select from the decoder, not write qualified
	input  logic                    mcs4N,
	input  logic                    mweN,
	// Offset inside the 8K window
	input  logic [12:0]             ma,
	// Current bank from the first latch group
	input  logic [bankWidth-1:0]    bank,
	// Banked ROM side
	output logic [bankWidth+12:0]   romAddr,
	output logic                    romOe
);

	logic readHit;

	// Only reads open the ROM
	assign readHit = ~mcs4N & mweN;

	//////////////////////////////////////////////////////////////////////
	// Read enable
	//////////////////////////////////////////////////////////////////////

	// One cycle behind the select
	always_ff @(posedge clk6M or negedge rstN) begin
		if (!rstN) begin
			romOe <= 1'b0;
		end else begin
			romOe <= readHit;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Address
	//////////////////////////////////////////////////////////////////////

	// Bank on top, window offset below
	// Holds the last read address between accesses
	always_ff @(posedge clk6M) begin
		if (readHit) begin
			romAddr <= {bank, ma};
		end
	end

endmodule

//--- hdl/mainCpuGlue.sv
`timescale 1ns/1ps

module mainCpuGlue
	import sys86VideoPkg::*;
#(
	parameter int WATCHDOG_WIDTH = 4
) (
	input  logic                        clk6M,
	input  logic                        rstN,
	input  logic                        clk0,
	// Main CPU bus
	input  logic [15:0]                 ma,
	input  logic [7:0]                  data,
	input  logic                        mweN,
	input  logic                        vblaN,
	// Sound CPU bus, acknowledge decode only
	input  logic [15:11]                sa,
	input  logic                        sweN,
	// Chip selects
	output logic                        mcs0N,
	output logic                        mcs1N,
	output logic                        mcs2N,
	output logic                        mcs3N,
	output logic                        mcs4N,
	output logic                        mromN,
	output logic                        lth0N,
	output logic                        lth1N,
	// Phase, reset, interrupts
	output logic                        q,
	output logic                        mresN,
	output logic                        mintN,
	output logic                        sintN,
	// Video latches
	output logic [planeCount-1:0][8:0]  scrollX,
	output logic [planeCount-1:0][7:0]  scrollY,
	output logic [planeCount-1:0][2:0]  prio,
	output logic [bankWidth-1:0]        bank0,
	output logic [bankWidth-1:0]        bank1,
	// Banked program ROM
	output logic [bankWidth+12:0]       romAddr,
	output logic                        romOe
);

	//////////////////////////////////////////////////////////////////////
	// Decoder drives the strobes
	//////////////////////////////////////////////////////////////////////

	mainAddrDecoder #(
		.WATCHDOG_WIDTH(WATCHDOG_WIDTH)
	) i_decoder (
		.clk6M (clk6M),
		.rstN  (rstN),
		.clk0  (clk0),
		.ma    (ma),
		.mweN  (mweN),
		.vblaN (vblaN),
		.sa    (sa),
		.sweN  (sweN),
		.mcs0N (mcs0N),
		.mcs1N (mcs1N),
		.mcs2N (mcs2N),
		.mcs3N (mcs3N),
		.mcs4N (mcs4N),
		.mromN (mromN),
		.lth0N (lth0N),
		.lth1N (lth1N),
		.q     (q),
		.mresN (mresN),
		.mintN (mintN),
		.sintN (sintN)
	);

	// Latches indexed by the low address bits
	scrollLatchBank i_latches (
		.clk6M   (clk6M),
		.rstN    (rstN),
		.lth0N   (lth0N),
		.lth1N   (lth1N),
		.offset  (ma[2:0]),
		.data    (data),
		.scrollX (scrollX),
		.scrollY (scrollY),
		.prio    (prio),
		.bank0   (bank0),
		.bank1   (bank1)
	);

	// First group's bank maps the 6000h window
	romBankMapper i_mapper (
		.clk6M   (clk6M),
		.rstN    (rstN),
		.mcs4N   (mcs4N),
		.mweN    (mweN),
		.ma      (ma[12:0]),
		.bank    (bank0),
		.romAddr (romAddr),
		.romOe   (romOe)
	);

endmodule

//--- tests/clockGen.sv
`timescale 1ns/1ps

module clockGen (
	output logic clk6M,
	output logic rstN
);

	// 4 ns period, starts low
	initial begin
		clk6M = 1'b0;
		forever #2 clk6M = ~clk6M;
	end

	// Reset held over three rising edges, released just after the third
	initial begin
		rstN = 1'b0;
		repeat (3) @(posedge clk6M);
		#1 rstN = 1'b1;
	end

endmodule

//--- tests/mainCpuGlue_properties.sv
`timescale 1ns/1ps

module mainCpuGlue_properties
	import sys86MapPkg::*;
(
	input logic                     clk6M,
	input logic                     rstN,
	input logic                     clk0,
	input logic [15:0]              ma,
	input logic                     mweN,
	input logic                     mcs0N,
	input logic                     mcs1N,
	input logic                     mcs2N,
	input logic                     mcs3N,
	input logic                     mcs4N,
	input logic                     mromN,
	input logic                     lth0N,
	input logic                     lth1N,
	input logic                     q,
	input logic                     romOe
);

	int                   failCount = 0;
	logic [3:0]           selExp;
	logic [1:0]           lthExp;
	logic                 windowRead;

	// Expected selects, order mcs2N mcs0N mcs1N mcs4N
	assign selExp = ~{ma[15:13] == regionSprite, ma[15:13] == regionVram0,
		ma[15:13] == regionVram1, ma[15:13] == regionRom6};
	// Latch strobes only on main writes
	assign lthExp = ~{!mweN && (ma[15:11] == addrLatch1Hi), !mweN && (ma[15:11] == addrLatch0Hi)};
	// Read cycle inside the 6000h window
	assign windowRead = (ma[15:13] == regionRom6) && mweN;

	//////////////////////////////////////////////////////////////////////
	// Decode
	//////////////////////////////////////////////////////////////////////

	mcs3High: assert property (@(posedge clk6M) disable iff (!rstN) mcs3N)
	else begin
		failCount++;
		$error("FAILED at %0t: mcs3N expected 1 got %b", $time, mcs3N);
	end

	selMap: assert property (@(posedge clk6M) disable iff (!rstN)
		{mcs2N, mcs0N, mcs1N, mcs4N} == selExp)
	else begin
		failCount++;
		$error("FAILED at %0t: mcs2N/0N/1N/4N expected %b got %b", $time, selExp,
			{mcs2N, mcs0N, mcs1N, mcs4N});
	end

	// Fixed ROM, reads at or above 8000h
	romSel: assert property (@(posedge clk6M) disable iff (!rstN) mromN == !(mweN && ma[15]))
	else begin
		failCount++;
		$error("FAILED at %0t: mromN expected %b got %b", $time, !(mweN && ma[15]), mromN);
	end

	lthMap: assert property (@(posedge clk6M) disable iff (!rstN) {lth1N, lth0N} == lthExp)
	else begin
		failCount++;
		$error("FAILED at %0t: lth1N/lth0N expected %b got %b", $time, lthExp, {lth1N, lth0N});
	end

	//////////////////////////////////////////////////////////////////////
	// Banked ROM and phase
	//////////////////////////////////////////////////////////////////////

	romHit: assert property (@(posedge clk6M) disable iff (!rstN) windowRead |=> romOe)
	else begin
		failCount++;
		$error("FAILED at %0t: romOe expected 1 got %b", $time, romOe);
	end

	romMiss: assert property (@(posedge clk6M) disable iff (!rstN) !windowRead |=> !romOe)
	else begin
		failCount++;
		$error("FAILED at %0t: romOe expected 0 got %b", $time, romOe);
	end

	phaseHold: assert property (@(posedge clk6M) disable iff (!rstN) !clk0 |=> !q)
	else begin
		failCount++;
		$error("FAILED at %0t: q expected 0 got %b", $time, q);
	end

endmodule

//--- tests/mainCpuGlueTb.sv
`timescale 1ns/1ps

module mainCpuGlueTb
	import sys86MapPkg::*;
	import sys86VideoPkg::*;
();

	localparam int watchdogWidth = 4;
	// Longest test sequence plus margin
	localparam int cycleLimit = 3000;
	localparam logic [15:0] idleAddr = 16'h0000;

	logic                          clk6M;
	logic                          rstN;
	logic                          clk0;
	logic [15:0]                   ma;
	logic [7:0]                    data;
	logic                          mweN;
	logic                          vblaN;
	logic [15:11]                  sa;
	logic                          sweN;
	logic                          mcs0N;
	logic                          mcs1N;
	logic                          mcs2N;
	logic                          mcs3N;
	logic                          mcs4N;
	logic                          mromN;
	logic                          lth0N;
	logic                          lth1N;
	logic                          q;
	logic                          mresN;
	logic                          mintN;
	logic                          sintN;
	logic [planeCount-1:0][8:0]    scrollX;
	logic [planeCount-1:0][7:0]    scrollY;
	logic [planeCount-1:0][2:0]    prio;
	logic [bankWidth-1:0]          bank0;
	logic [bankWidth-1:0]          bank1;
	logic [bankWidth+12:0]         romAddr;
	logic                          romOe;

	// Reference state
	logic [8:0]                    sxRef [planeCount];
	logic [7:0]                    syRef [planeCount];
	logic [2:0]                    prioRef [planeCount];
	logic [bankWidth-1:0]          bankRef [2];
	logic [watchdogWidth-1:0]      wdRef;
	logic                          mintRef;
	logic                          sintRef;
	logic [1:0]                    phaseRef;

	int                            seed = 97030;
	int                            checkErrors = 0;
	int                            cycleCount = 0;
	logic [15:0]                   addr;

	clockGen i_clock (
		.clk6M (clk6M),
		.rstN  (rstN)
	);

	mainCpuGlue #(
		.WATCHDOG_WIDTH(watchdogWidth)
	) i_dut (
		.clk6M (clk6M), .rstN (rstN), .clk0 (clk0), .ma (ma), .data (data),
		.mweN (mweN), .vblaN (vblaN), .sa (sa), .sweN (sweN),
		.mcs0N (mcs0N), .mcs1N (mcs1N), .mcs2N (mcs2N), .mcs3N (mcs3N),
		.mcs4N (mcs4N), .mromN (mromN), .lth0N (lth0N), .lth1N (lth1N),
		.q (q), .mresN (mresN), .mintN (mintN), .sintN (sintN),
		.scrollX (scrollX), .scrollY (scrollY), .prio (prio),
		.bank0 (bank0), .bank1 (bank1), .romAddr (romAddr), .romOe (romOe)
	);

	bind mainCpuGlue mainCpuGlue_properties i_props (
		.clk6M (clk6M), .rstN (rstN), .clk0 (clk0), .ma (ma), .mweN (mweN),
		.mcs0N (mcs0N), .mcs1N (mcs1N), .mcs2N (mcs2N), .mcs3N (mcs3N),
		.mcs4N (mcs4N), .mromN (mromN), .lth0N (lth0N), .lth1N (lth1N),
		.q (q), .romOe (romOe)
	);

	// Run limit
	always @(posedge clk6M) begin
		cycleCount++;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycleLimit);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	// Inputs change 1 ns after the rising edge
	task automatic tick();
		@(posedge clk6M);
		#1;
	endtask

	task automatic compareValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			checkErrors++;
			$display("FAILED at %0t: %s expected %0h got %0h", $time, name, expected, actual);
		end
	endtask

	task automatic checkStatus();
		compareValue("mresN", !wdRef[watchdogWidth-1], mresN);
		compareValue("mintN", mintRef, mintN);
		compareValue("sintN", sintRef, sintN);
	endtask

	task automatic checkLatches();
		for (int p = 0; p < planeCount; p++) begin
			compareValue($sformatf("scrollX[%0d]", p), sxRef[p], scrollX[p]);
			compareValue($sformatf("scrollY[%0d]", p), syRef[p], scrollY[p]);
			compareValue($sformatf("prio[%0d]", p), prioRef[p], prio[p]);
		end
		compareValue("bank0", bankRef[0], bank0);
		compareValue("bank1", bankRef[1], bank1);
	endtask

	// Offset bit 2 picks the plane, low bits the register
	task automatic applyLatchWrite(input int group, input logic [2:0] off, input logic [7:0] d);
		int plane;
		plane = group * 2 + off[2];
		case (off[1:0])
			2'd0: sxRef[plane][7:0] = d;
			2'd1: begin
				sxRef[plane][8] = d[0];
				prioRef[plane] = d[7:5];
			end
			2'd2: syRef[plane] = d;
			default: begin
				// Bank only on the first plane, offset 7 is a hole
				if (!off[2]) begin
					bankRef[group] = d[bankWidth-1:0];
				end
			end
		endcase
	endtask

	task automatic busWrite(input logic [15:0] a, input logic [7:0] d);
		ma = a;
		data = d;
		mweN = 1'b0;
		tick();
		if (a[15:11] == addrWatchdogHi) begin
			wdRef = '0;
		end else if (a[15:11] == addrMainAckHi) begin
			mintRef = 1'b1;
		end else if (a[15:11] == addrLatch0Hi || a[15:11] == addrLatch1Hi) begin
			applyLatchWrite(a[11], a[2:0], d);
		end
		ma = idleAddr;
		mweN = 1'b1;
		checkLatches();
		checkStatus();
		compareValue("romOe", 0, romOe);
	endtask

	task automatic busRead(input logic [15:0] a);
		ma = a;
		tick();
		if (a[15:13] == regionRom6) begin
			compareValue("romOe", 1, romOe);
			compareValue("romAddr", {bankRef[0], a[12:0]}, romAddr);
		end else begin
			compareValue("romOe", 0, romOe);
		end
		ma = idleAddr;
		checkStatus();
	endtask

	// Edge is seen on the second clock after vblaN drops
	task automatic vblankPulse();
		vblaN = 1'b0;
		tick();
		checkStatus();
		tick();
		wdRef = (wdRef == watchdogWrap) ? '0 : wdRef + 1'b1;
		mintRef = 1'b0;
		sintRef = 1'b0;
		checkStatus();
		vblaN = 1'b1;
		tick();
		checkStatus();
	endtask

	task automatic soundWrite(input logic [15:11] a);
		sa = a;
		sweN = 1'b0;
		tick();
		if (a == addrSoundAckHi) begin
			sintRef = 1'b1;
		end
		sa = '0;
		sweN = 1'b1;
		checkStatus();
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	initial begin
		clk0 = 1'b1;
		ma = idleAddr;
		data = 8'h00;
		mweN = 1'b1;
		vblaN = 1'b1;
		sa = '0;
		sweN = 1'b1;
		for (int p = 0; p < planeCount; p++) begin
			sxRef[p] = '0;
			syRef[p] = '0;
			prioRef[p] = '0;
		end
		bankRef[0] = '0;
		bankRef[1] = '0;
		wdRef = '0;
		mintRef = 1'b1;
		sintRef = 1'b1;
		phaseRef = '0;

		// Reset values, before any edge with reset released
		wait (rstN === 1'b1);
		checkStatus();
		checkLatches();
		compareValue("romOe", 0, romOe);

		// Phase counter, cleared then free running
		clk0 = 1'b0;
		repeat (2) begin
			tick();
			phaseRef = '0;
			compareValue("q", 0, q);
		end
		clk0 = 1'b1;
		repeat (10) begin
			tick();
			phaseRef = phaseRef + 2'd1;
			compareValue("q", phaseRef[1] ^ phaseRef[0], q);
		end

		// Every offset of both latch groups, twice
		repeat (2) begin
			for (int off = 0; off < 8; off++) begin
				busWrite({addrLatch0Hi, 8'h00, 3'(off)}, 8'($random(seed)));
				busWrite({addrLatch1Hi, 8'h00, 3'(off)}, 8'($random(seed)));
			end
		end

		// Banked window reads around bank changes
		repeat (6) begin
			busWrite({addrLatch0Hi, 8'h00, offBank}, 8'($random(seed)));
			busWrite({addrLatch1Hi, 8'h00, offBank}, 8'($random(seed)));
			repeat (3) busRead({regionRom6, 13'($random(seed))});
			busWrite({regionRom6, 13'($random(seed))}, 8'($random(seed)));
			busRead({regionVram0, 13'($random(seed))});
		end

		// Random mix of reads and writes over the whole map
		repeat (200) begin
			addr = 16'($random(seed));
			if ($random(seed) & 1) begin
				busWrite(addr, 8'($random(seed)));
			end else begin
				busRead(addr);
			end
		end

		// Interrupts, each CPU clears only its own
		vblankPulse();
		soundWrite(addrMainAckHi);
		soundWrite(addrSoundAckHi);
		busWrite({addrMainAckHi, 11'h000}, 8'h00);
		vblankPulse();
		busWrite({addrMainAckHi, 11'h000}, 8'h00);
		soundWrite(addrSoundAckHi);

		// Watchdog runs into reset and wraps
		busWrite({addrWatchdogHi, 11'h000}, 8'h00);
		repeat (13) vblankPulse();

		// Regular kicks keep reset away
		repeat (20) begin
			busWrite({addrWatchdogHi, 11'h000}, 8'h00);
			vblankPulse();
		end

		$display("Errors: checks %0d, assertions %0d", checkErrors, i_dut.i_props.failCount);
		if (checkErrors == 0 && i_dut.i_props.failCount == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

//--- sim.f
hdl/sys86MapPkg.sv
hdl/sys86VideoPkg.sv
hdl/mainAddrDecoder.sv
hdl/scrollLatchBank.sv
hdl/romBankMapper.sv
hdl/mainCpuGlue.sv
tests/clockGen.sv
tests/mainCpuGlue_properties.sv
tests/mainCpuGlueTb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module mainCpuGlueTb -f sim.f

# Let the testbench count every assertion failure itself
output=$(./obj_dir/VmainCpuGlueTb +verilator+error+limit+10000 2>&1) || true
echo "$output"

if grep -qF "*** TEST PASSED ***" <<< "$output"; then
	exit 0
fi
exit 1
